//--- Bender.yml
package:
  name: garegga_scroll

sources:
  - video_timing_pkg.sv
  - scroll_tile_pkg.sv
  - layer_ctrl_if.sv
  - line_scheduler.sv
  - scroll_layer_render.sv
  - scroll_line_output.sv
  - garegga_scroll_top.sv
  - target: test
    files:
      - tb_scroll.sv

//--- files.f
video_timing_pkg.sv
scroll_tile_pkg.sv
layer_ctrl_if.sv
line_scheduler.sv
scroll_layer_render.sv
scroll_line_output.sv
garegga_scroll_top.sv
tb_scroll.sv

//--- garegga_scroll_top.sv
module garegga_scroll_top (
    input  logic                                clk96_i,
    input  logic                                reset96_i,
    input  logic                                pixel_cen_i,
    input  logic                                active_i,
    input  logic                                hblank_i,
    input  logic [video_timing_pkg::hpos_w-1:0] vrender_i,
    input  logic [video_timing_pkg::hpos_w-1:0] h_i,
    output scroll_tile_pkg::tilemap_addr_t scr0_map_addr_o, scr1_map_addr_o, scr2_map_addr_o,
    input  scroll_tile_pkg::tilemap_word_t scr0_map_dout_i, scr1_map_dout_i, scr2_map_dout_i,
    output logic                           scr0_gfx_cs_o, scr1_gfx_cs_o, scr2_gfx_cs_o,
    input  logic                           scr0_gfx_ok_i, scr1_gfx_ok_i, scr2_gfx_ok_i,
    output scroll_tile_pkg::gfx_num_t      scr0_gfx_num_o, scr1_gfx_num_o, scr2_gfx_num_o,
    output scroll_tile_pkg::gfx_offs_t     scr0_gfx_offs_o, scr1_gfx_offs_o, scr2_gfx_offs_o,
    output scroll_tile_pkg::gfx_bank_t     scr0_gfx_bank_o, scr1_gfx_bank_o, scr2_gfx_bank_o,
    input  scroll_tile_pkg::gfx_data_t     scr0_gfx_data_i, scr1_gfx_data_i, scr2_gfx_data_i,
    input  scroll_tile_pkg::scroll_t       scr0_scroll_x_i, scr1_scroll_x_i, scr2_scroll_x_i,
    input  scroll_tile_pkg::scroll_t       scr0_scroll_y_i, scr1_scroll_y_i, scr2_scroll_y_i,
    input  scroll_tile_pkg::scroll_t  scr0_scroll_xoffs_i, scr1_scroll_xoffs_i, scr2_scroll_xoffs_i,
    input  scroll_tile_pkg::scroll_t  scr0_scroll_yoffs_i, scr1_scroll_yoffs_i, scr2_scroll_yoffs_i,
    output scroll_tile_pkg::pixel_t        scr0_pixel_o, scr1_pixel_o, scr2_pixel_o
);
    import video_timing_pkg::*;
    import scroll_tile_pkg::*;

    // tilemap and graphics rom side of the three layers
    tilemap_addr_t [num_layers-1:0] map_addr;
    tilemap_word_t [num_layers-1:0] map_dout;
    logic          [num_layers-1:0] gfx_cs;
    logic          [num_layers-1:0] gfx_ok;
    gfx_num_t      [num_layers-1:0] gfx_num;
    gfx_offs_t     [num_layers-1:0] gfx_offs;
    gfx_bank_t     [num_layers-1:0] gfx_bank;
    gfx_data_t     [num_layers-1:0] gfx_data;

    scroll_t           scroll_x     [num_layers];
    scroll_t           scroll_y     [num_layers];
    scroll_t           scroll_xoffs [num_layers];
    scroll_t           scroll_yoffs [num_layers];
    logic              buf_we       [num_layers];
    logic [hpos_w-1:0] buf_addr     [num_layers];
    pixel_t            buf_data     [num_layers];
    pixel_t            pixel        [num_layers];

    layer_ctrl_if ctrl [num_layers] ();

    assign map_dout     = {scr2_map_dout_i, scr1_map_dout_i, scr0_map_dout_i};
    assign gfx_ok       = {scr2_gfx_ok_i, scr1_gfx_ok_i, scr0_gfx_ok_i};
    assign gfx_data     = {scr2_gfx_data_i, scr1_gfx_data_i, scr0_gfx_data_i};
    assign scroll_x     = '{scr0_scroll_x_i, scr1_scroll_x_i, scr2_scroll_x_i};
    assign scroll_y     = '{scr0_scroll_y_i, scr1_scroll_y_i, scr2_scroll_y_i};
    assign scroll_xoffs = '{scr0_scroll_xoffs_i, scr1_scroll_xoffs_i, scr2_scroll_xoffs_i};
    assign scroll_yoffs = '{scr0_scroll_yoffs_i, scr1_scroll_yoffs_i, scr2_scroll_yoffs_i};

    assign {scr2_map_addr_o, scr1_map_addr_o, scr0_map_addr_o} = map_addr;
    assign {scr2_gfx_cs_o, scr1_gfx_cs_o, scr0_gfx_cs_o}       = gfx_cs;
    assign {scr2_gfx_num_o, scr1_gfx_num_o, scr0_gfx_num_o}    = gfx_num;
    assign {scr2_gfx_offs_o, scr1_gfx_offs_o, scr0_gfx_offs_o} = gfx_offs;
    assign {scr2_gfx_bank_o, scr1_gfx_bank_o, scr0_gfx_bank_o} = gfx_bank;
    assign scr0_pixel_o = pixel[0];
    assign scr1_pixel_o = pixel[1];
    assign scr2_pixel_o = pixel[2];

    line_scheduler i_line_scheduler (
        .clk96_i        (clk96_i),
        .reset96_i      (reset96_i),
        .hblank_i       (hblank_i),
        .scroll_x_i     (scroll_x),
        .scroll_y_i     (scroll_y),
        .scroll_xoffs_i (scroll_xoffs),
        .scroll_yoffs_i (scroll_yoffs),
        .ctrl           (ctrl)
    );

    for (genvar g = 0; g < num_layers; g++) begin : g_layer
        scroll_layer_render i_render (
            .clk96_i    (clk96_i),
            .reset96_i  (reset96_i),
            .vrender_i  (vrender_i),
            .ctrl       (ctrl[g]),
            .map_addr_o (map_addr[g]),
            .map_dout_i (map_dout[g]),
            .gfx_cs_o   (gfx_cs[g]),
            .gfx_ok_i   (gfx_ok[g]),
            .gfx_num_o  (gfx_num[g]),
            .gfx_offs_o (gfx_offs[g]),
            .gfx_bank_o (gfx_bank[g]),
            .gfx_data_i (gfx_data[g]),
            .buf_we_o   (buf_we[g]),
            .buf_addr_o (buf_addr[g]),
            .buf_data_o (buf_data[g])
        );
    end

    scroll_line_output i_line_output (
        .clk96_i     (clk96_i),
        .reset96_i   (reset96_i),
        .hblank_i    (hblank_i),
        .pixel_cen_i (pixel_cen_i),
        .active_i    (active_i),
        .h_i         (h_i),
        .buf_we_i    (buf_we),
        .buf_addr_i  (buf_addr),
        .buf_data_i  (buf_data),
        .pixel_o     (pixel)
    );

endmodule

//--- layer_ctrl_if.sv
interface layer_ctrl_if;
    import scroll_tile_pkg::*;

    logic    start;       // one cycle, line begins
    logic    done;        // one cycle, line finished
    scroll_t scroll_x;    // position + offset, held until done
    scroll_t scroll_y;

    modport scheduler (
        output start,
        output scroll_x,
        output scroll_y,
        input  done
    );

    modport renderer (
        input  start,
        input  scroll_x,
        input  scroll_y,
        output done
    );

endinterface

//--- line_scheduler.sv
module line_scheduler (
    input  logic                     clk96_i,
    input  logic                     reset96_i,
    input  logic                     hblank_i,
    input  scroll_tile_pkg::scroll_t scroll_x_i     [video_timing_pkg::num_layers],
    input  scroll_tile_pkg::scroll_t scroll_y_i     [video_timing_pkg::num_layers],
    input  scroll_tile_pkg::scroll_t scroll_xoffs_i [video_timing_pkg::num_layers],
    input  scroll_tile_pkg::scroll_t scroll_yoffs_i [video_timing_pkg::num_layers],
    layer_ctrl_if.scheduler          ctrl           [video_timing_pkg::num_layers]
);
    import video_timing_pkg::*;
    import scroll_tile_pkg::*;

    logic                  hblank_q;
    logic                  busy_q;
    logic                  start_q;
    logic [num_layers-1:0] done_mask_q;    // layers finished so far
    logic [num_layers-1:0] done_now;
    logic                  launch;

    // blank start while idle, a busy blank edge is dropped
    assign launch = hblank_i & ~hblank_q & ~busy_q;

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            hblank_q    <= 1'b0;
            busy_q      <= 1'b0;
            start_q     <= 1'b0;
            done_mask_q <= '0;
        end else begin
            hblank_q <= hblank_i;
            start_q  <= launch;
            if (launch) begin
                busy_q      <= 1'b1;
                done_mask_q <= '0;
            end else if (busy_q) begin
                if (&(done_mask_q | done_now)) begin
                    busy_q      <= 1'b0;    // all layers in
                    done_mask_q <= '0;
                end else begin
                    done_mask_q <= done_mask_q | done_now;
                end
            end
        end
    end

    for (genvar g = 0; g < num_layers; g++) begin : g_layer
        scroll_t sum_x_q;
        scroll_t sum_y_q;

        // latched with start, stable for the whole line
        always_ff @(posedge clk96_i) begin
            if (launch) begin
                sum_x_q <= scroll_x_i[g] + scroll_xoffs_i[g];
                sum_y_q <= scroll_y_i[g] + scroll_yoffs_i[g];
            end
        end

        assign ctrl[g].start    = start_q;
        assign ctrl[g].scroll_x = sum_x_q;
        assign ctrl[g].scroll_y = sum_y_q;
        assign done_now[g]      = ctrl[g].done;
    end

endmodule

//--- scroll_input.txt
// per layer 0..2: scroll_x scroll_y scroll_xoffs scroll_yoffs, then vrender, check h,
// expected pixel layer 0, layer 1, layer 2 {prio, pal, code}
0000 0000 0000 0000  0000 0000 0000 0000  0000 0000 0000 0000  0000 0028  102B 103B 104B
0003 0000 0001 0000  0010 0000 0003 0000  0000 0000 0000 0000  0000 0028  102F 184F 104B
0000 0025 0000 0000  0000 0000 0000 0013  0000 01F0 0000 0020  000A 0029  1423 1231 124E
0050 0000 0000 0000  0040 0000 0010 0000  0000 0000 0000 0000  0004 0029  0000 0000 0000
0123 0000 0005 0008  01F0 0003 001F 0004  00A0 0100 0000 0000  0064 00C8  7DF4 6CE8 3583
001F 0000 0000 0000  001A 0000 0000 0000  0024 0000 1FFE 0000  0000 0000  0811 082C 1045

//--- scroll_layer_render.sv
module scroll_layer_render (
    input  logic                                   clk96_i,
    input  logic                                   reset96_i,
    input  logic [video_timing_pkg::hpos_w-1:0]    vrender_i,
    layer_ctrl_if.renderer                         ctrl,
    output scroll_tile_pkg::tilemap_addr_t         map_addr_o,
    input  scroll_tile_pkg::tilemap_word_t         map_dout_i,
    output logic                                   gfx_cs_o,
    input  logic                                   gfx_ok_i,
    output scroll_tile_pkg::gfx_num_t              gfx_num_o,
    output scroll_tile_pkg::gfx_offs_t             gfx_offs_o,
    output scroll_tile_pkg::gfx_bank_t             gfx_bank_o,
    input  scroll_tile_pkg::gfx_data_t             gfx_data_i,
    output logic                                   buf_we_o,
    output logic [video_timing_pkg::hpos_w-1:0]    buf_addr_o,
    output scroll_tile_pkg::pixel_t                buf_data_o
);
    import video_timing_pkg::*;
    import scroll_tile_pkg::*;

    render_state_t                       state_q;
    logic [$clog2(tiles_per_line)-1:0]   col_idx_q;    // column within the line
    logic                                slice_q;      // left or right half of the tile
    logic [$clog2(slice_px)-1:0]         px_q;
    logic                                done_q;
    tilemap_word_t                       tile_q;
    tilemap_word_t                       attr_q;
    gfx_data_t                           data_q;
    logic [hpos_w:0]                     vsum;
    logic [map_col_w-1:0]                row;
    logic [map_col_w-1:0]                col;
    logic [3:0]                          px_code;
    logic signed [10:0]                  px_x;
    logic                                px_vis;
    logic                                last_px;
    logic                                last_col;

    assign vsum = vrender_i + ctrl.scroll_y[3:0];
    assign row  = map_col_w'(ctrl.scroll_y[8:4] + vsum[8:4]);    // wraps at 32
    assign col  = map_col_w'(ctrl.scroll_x[8:4] + col_idx_q);

    // number word (odd) first, attribute word (even) while the number comes back
    assign map_addr_o = {row, col, state_q != rs_tile_rd};

    assign px_code = data_q[{px_q, 2'b00} +: 4];
    assign px_x    = 11'(col_idx_q * tile_px) + 11'(slice_q * slice_px) + 11'(px_q)
                   - 11'(ctrl.scroll_x[3:0]);
    assign px_vis  = (px_x >= 0) && (px_x < screen_w);
    assign last_px  = px_q == ($clog2(slice_px))'(slice_px - 1);
    assign last_col = col_idx_q == ($clog2(tiles_per_line))'(tiles_per_line - 1);

    assign ctrl.done = done_q;

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            state_q   <= rs_idle;
            col_idx_q <= '0;
            slice_q   <= 1'b0;
            px_q      <= '0;
            gfx_cs_o  <= 1'b0;
            buf_we_o  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            buf_we_o <= 1'b0;
            done_q   <= 1'b0;
            case (state_q)
                rs_idle: if (ctrl.start) begin
                    col_idx_q <= '0;
                    state_q   <= rs_map_addr;
                end
                rs_map_addr: begin
                    slice_q <= 1'b0;
                    state_q <= rs_tile_rd;
                end
                rs_tile_rd: begin
                    if (map_dout_i != '0) begin
                        state_q <= rs_attr_rd;
                    end else if (last_col) begin
                        state_q <= rs_done;    // blank tile ends the line
                    end else begin
                        col_idx_q <= col_idx_q + 1'b1;
                        state_q   <= rs_map_addr;
                    end
                end
                rs_attr_rd: state_q <= rs_gfx_req;
                rs_gfx_req: begin
                    gfx_cs_o <= 1'b1;
                    state_q  <= rs_gfx_wait;
                end
                rs_gfx_wait: if (gfx_ok_i) begin
                    gfx_cs_o <= 1'b0;
                    px_q     <= '0;
                    state_q  <= rs_pix_wr;
                end
                rs_pix_wr: begin
                    buf_we_o <= (px_code != 4'd0) && px_vis;    // transparent or clipped
                    px_q     <= px_q + 1'b1;
                    if (last_px) begin
                        if (!slice_q) begin
                            slice_q <= 1'b1;
                            state_q <= rs_gfx_req;
                        end else if (last_col) begin
                            state_q <= rs_done;
                        end else begin
                            col_idx_q <= col_idx_q + 1'b1;
                            state_q   <= rs_map_addr;
                        end
                    end
                end
                rs_done: begin
                    done_q  <= 1'b1;
                    state_q <= rs_idle;
                end
                default: state_q <= rs_idle;
            endcase
        end
    end

    always_ff @(posedge clk96_i) begin
        if (state_q == rs_tile_rd) tile_q <= map_dout_i;
        if (state_q == rs_attr_rd) attr_q <= map_dout_i;
        if (state_q == rs_gfx_req) begin
            gfx_num_o  <= {tile_q[12:0], 2'b00};
            gfx_bank_o <= tile_q[15:13];
            // lower 8 lines at +64, right slice at +32, 4 bytes per line
            gfx_offs_o <= {9'd0, vsum[3], slice_q, vsum[2:0], 2'b00};
        end
        if (state_q == rs_gfx_wait && gfx_ok_i) data_q <= gfx_data_i;
        buf_addr_o <= px_x[hpos_w-1:0];
        buf_data_o <= '{prio: attr_q[11:8], pal: attr_q[6:0], code: px_code};
    end

endmodule

//--- scroll_line_output.sv
module scroll_line_output (
    input  logic                                clk96_i,
    input  logic                                reset96_i,
    input  logic                                hblank_i,
    input  logic                                pixel_cen_i,
    input  logic                                active_i,
    input  logic [video_timing_pkg::hpos_w-1:0] h_i,
    input  logic                                buf_we_i   [video_timing_pkg::num_layers],
    input  logic [video_timing_pkg::hpos_w-1:0] buf_addr_i [video_timing_pkg::num_layers],
    input  scroll_tile_pkg::pixel_t             buf_data_i [video_timing_pkg::num_layers],
    output scroll_tile_pkg::pixel_t             pixel_o    [video_timing_pkg::num_layers]
);
    import video_timing_pkg::*;
    import scroll_tile_pkg::*;

    logic            hblank_q;
    logic            front_q;      // bank being displayed
    logic [hpos_w:0] clr_cnt_q;    // zero sweep of both banks after reset
    logic            clearing;
    logic            rd_en;

    assign clearing = ~clr_cnt_q[hpos_w];
    assign rd_en    = pixel_cen_i & active_i & ~clearing;

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            hblank_q  <= 1'b0;
            front_q   <= 1'b0;
            clr_cnt_q <= '0;
        end else begin
            hblank_q <= hblank_i;
            if (hblank_q && !hblank_i) front_q <= ~front_q;    // swap at blank end
            if (clearing) clr_cnt_q <= clr_cnt_q + 1'b1;
        end
    end

    for (genvar g = 0; g < num_layers; g++) begin : g_layer
        pixel_t bank_rd [2];

        for (genvar b = 0; b < 2; b++) begin : g_bank
            pixel_t              mem [buf_depth];
            logic                is_front;
            logic                we;
            logic [hpos_w-1:0]   addr;
            pixel_t              din;

            // front bank is erased behind the read, back bank takes renderer writes
            assign is_front = front_q == 1'(b);
            assign we   = clearing | (is_front ? rd_en : buf_we_i[g]);
            assign addr = clearing ? clr_cnt_q[hpos_w-1:0] : (is_front ? h_i : buf_addr_i[g]);
            assign din  = (clearing | is_front) ? '0 : buf_data_i[g];

            always_ff @(posedge clk96_i) begin
                if (we) mem[addr] <= din;
            end

            assign bank_rd[b] = mem[h_i];
        end

        always_ff @(posedge clk96_i or posedge reset96_i) begin
            if (reset96_i) pixel_o[g] <= '0;
            else if (rd_en) pixel_o[g] <= bank_rd[front_q];
        end
    end

endmodule

//--- scroll_tile_pkg.sv
package scroll_tile_pkg;

    typedef logic signed [12:0] scroll_t;    // position, offset and their sum

    // tilemap ram, two words per entry (attribute, then number)
    localparam int map_cols  = 32;
    localparam int map_col_w = $clog2(map_cols);

    typedef logic [10:0] tilemap_addr_t;
    typedef logic [15:0] tilemap_word_t;

    // graphics rom request and data
    typedef logic [31:0] gfx_data_t;    // eight 4-bit pixels, pixel 0 in the low nibble
    typedef logic [14:0] gfx_num_t;
    typedef logic [15:0] gfx_offs_t;
    typedef logic [2:0]  gfx_bank_t;

    typedef struct packed {
        logic [3:0] prio;
        logic [6:0] pal;
        logic [3:0] code;    // 0 is transparent
    } pixel_t;

    typedef enum logic [2:0] {
        rs_idle,
        rs_map_addr,    // tile number address on the bus
        rs_tile_rd,
        rs_attr_rd,
        rs_gfx_req,
        rs_gfx_wait,
        rs_pix_wr,
        rs_done
    } render_state_t;

endpackage

//--- tb_scroll.sv
module tb_scroll;
    timeunit 1ns;
    timeprecision 1ps;

    import video_timing_pkg::*;
    import scroll_tile_pkg::*;

    localparam int num_vec    = 6;
    localparam int vec_words  = 17;      // 4 scroll words per layer, v, h, 3 pixels
    localparam int line_cyc   = 4096;    // 512 pixels of 8 clocks
    localparam int wait_limit = 5000;

    logic              clk96;
    logic              reset96;
    logic              pixel_cen;
    logic              active;
    logic              hblank;
    logic [8:0]        vrender;
    logic [8:0]        h;
    tilemap_addr_t     map_addr   [num_layers];
    tilemap_addr_t     map_addr_q [num_layers];
    tilemap_word_t     map_dout   [num_layers];
    logic              gfx_cs     [num_layers];
    logic              gfx_ok     [num_layers];
    gfx_num_t          gfx_num    [num_layers];
    gfx_offs_t         gfx_offs   [num_layers];
    gfx_bank_t         gfx_bank   [num_layers];
    gfx_data_t         gfx_data   [num_layers];
    scroll_t           scroll_x   [num_layers];
    scroll_t           scroll_y   [num_layers];
    scroll_t           scroll_xo  [num_layers];
    scroll_t           scroll_yo  [num_layers];
    pixel_t            pixel      [num_layers];
    pixel_t            expected   [num_layers];
    int                gfx_wait   [num_layers];
    logic [15:0]       vec_mem    [num_vec * vec_words];
    logic [15:0]       lfsr_q;
    int                cyc;
    int                check_h;
    int                value_errors;
    int                other_errors;

    garegga_scroll_top i_garegga_scroll_top (
        .clk96_i (clk96), .reset96_i (reset96), .pixel_cen_i (pixel_cen),
        .active_i (active), .hblank_i (hblank), .vrender_i (vrender), .h_i (h),
        .scr0_map_addr_o (map_addr[0]), .scr1_map_addr_o (map_addr[1]),
        .scr2_map_addr_o (map_addr[2]),
        .scr0_map_dout_i (map_dout[0]), .scr1_map_dout_i (map_dout[1]),
        .scr2_map_dout_i (map_dout[2]),
        .scr0_gfx_cs_o (gfx_cs[0]), .scr1_gfx_cs_o (gfx_cs[1]), .scr2_gfx_cs_o (gfx_cs[2]),
        .scr0_gfx_ok_i (gfx_ok[0]), .scr1_gfx_ok_i (gfx_ok[1]), .scr2_gfx_ok_i (gfx_ok[2]),
        .scr0_gfx_num_o (gfx_num[0]), .scr1_gfx_num_o (gfx_num[1]),
        .scr2_gfx_num_o (gfx_num[2]),
        .scr0_gfx_offs_o (gfx_offs[0]), .scr1_gfx_offs_o (gfx_offs[1]),
        .scr2_gfx_offs_o (gfx_offs[2]),
        .scr0_gfx_bank_o (gfx_bank[0]), .scr1_gfx_bank_o (gfx_bank[1]),
        .scr2_gfx_bank_o (gfx_bank[2]),
        .scr0_gfx_data_i (gfx_data[0]), .scr1_gfx_data_i (gfx_data[1]),
        .scr2_gfx_data_i (gfx_data[2]),
        .scr0_scroll_x_i (scroll_x[0]), .scr1_scroll_x_i (scroll_x[1]),
        .scr2_scroll_x_i (scroll_x[2]),
        .scr0_scroll_y_i (scroll_y[0]), .scr1_scroll_y_i (scroll_y[1]),
        .scr2_scroll_y_i (scroll_y[2]),
        .scr0_scroll_xoffs_i (scroll_xo[0]), .scr1_scroll_xoffs_i (scroll_xo[1]),
        .scr2_scroll_xoffs_i (scroll_xo[2]),
        .scr0_scroll_yoffs_i (scroll_yo[0]), .scr1_scroll_yoffs_i (scroll_yo[1]),
        .scr2_scroll_yoffs_i (scroll_yo[2]),
        .scr0_pixel_o (pixel[0]), .scr1_pixel_o (pixel[1]), .scr2_pixel_o (pixel[2])
    );

    initial begin
        clk96 = 1'b0;
        forever #10 clk96 = ~clk96;
    end

    // tile number on odd addresses, attribute on even ones
    function automatic tilemap_word_t map_word(input int layer, input tilemap_addr_t addr);
        int e;
        e = int'(addr[10:1]);
        if (addr[0]) return (e % 7 == 0) ? 16'd0 : 16'(e + 1 + 64 * layer);
        return {4'd0, 4'(e % 16), 1'b0, 7'((e + layer) % 128)};
    endfunction

    function automatic gfx_data_t gfx_word(input gfx_num_t num, input gfx_offs_t offs);
        gfx_data_t d;
        for (int k = 0; k < 8; k++) d[4*k +: 4] = 4'(num[5:2] + offs[5:2] + k);
        return d;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // delay of 1 to 8 cycles from three lfsr steps
    task automatic draw_delay(output int d);
        logic [2:0] bits;
        bits = '0;
        repeat (3) begin
            bits   = {bits[1:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        d = int'(bits) + 1;
    endtask

    // synchronous tilemap ram returns the word of last cycle's address
    always @(posedge clk96) begin
        for (int l = 0; l < num_layers; l++) map_addr_q[l] <= map_addr[l];
    end

    always @(negedge clk96) begin
        for (int l = 0; l < num_layers; l++) map_dout[l] = map_word(l, map_addr_q[l]);
    end

    always @(negedge clk96) begin
        for (int l = 0; l < num_layers; l++) begin
            if (gfx_ok[l]) begin
                gfx_ok[l] = 1'b0;    // cs already dropped
            end else if (gfx_cs[l]) begin
                if (gfx_wait[l] == 0) draw_delay(gfx_wait[l]);
                gfx_wait[l]--;
                if (gfx_wait[l] == 0) begin
                    gfx_ok[l]   = 1'b1;
                    gfx_data[l] = gfx_word(gfx_num[l], gfx_offs[l]);
                    // every tile of the map model lies in bank 0
                    assert (gfx_bank[l] === 3'd0) else begin
                        value_errors++;
                        $display("CHECK FAILED at %0t: scr%0d_gfx_bank_o expected 0 got %0d",
                                 $time, l, gfx_bank[l]);
                    end
                end
            end
        end
    end

    // video timing with pixel_cen on the last clock of each pixel
    task automatic tick();
        @(negedge clk96);
        cyc       = (cyc + 1) % line_cyc;
        h         = 9'(cyc >> 3);
        pixel_cen = (cyc % 8) == 7;
        hblank    = h >= screen_w;
        active    = ~hblank;
    endtask

    task automatic wait_blank(input logic level, output bit ok);
        int n;
        n = 0;
        while (hblank !== level && n < wait_limit) begin
            tick();
            n++;
        end
        ok = hblank === level;
        if (!ok) $display("timeout at %0t waiting for hblank to go %0b", $time, level);
    endtask

    task automatic wait_column(input int col, output bit ok);
        int n;
        n = 0;
        while (!(pixel_cen && h == col) && n < wait_limit) begin
            tick();
            n++;
        end
        ok = pixel_cen && h == col;
        if (!ok) $display("timeout at %0t waiting for column %0d", $time, col);
    endtask

    task automatic apply_vector(input int v);
        int b;
        b = v * vec_words;
        for (int l = 0; l < num_layers; l++) begin
            scroll_x[l]  = vec_mem[b + 4*l][12:0];
            scroll_y[l]  = vec_mem[b + 4*l + 1][12:0];
            scroll_xo[l] = vec_mem[b + 4*l + 2][12:0];
            scroll_yo[l] = vec_mem[b + 4*l + 3][12:0];
            expected[l]  = vec_mem[b + 14 + l][14:0];
        end
        vrender = vec_mem[b + 12][8:0];
        check_h = int'(vec_mem[b + 13]);
    endtask

    task automatic check_idle();
        for (int l = 0; l < num_layers; l++) begin
            assert (gfx_cs[l] === 1'b0) else begin
                value_errors++;
                $display("CHECK FAILED at %0t: scr%0d_gfx_cs_o expected 0 got %b",
                         $time, l, gfx_cs[l]);
            end
            assert (pixel[l] === '0) else begin
                value_errors++;
                $display("CHECK FAILED at %0t: scr%0d_pixel_o expected 0000 got %h",
                         $time, l, pixel[l]);
            end
        end
    endtask

    task automatic check_pixels(input int v);
        for (int l = 0; l < num_layers; l++) begin
            assert (pixel[l] === expected[l]) else begin
                value_errors++;
                $display("CHECK FAILED at %0t: scr%0d_pixel_o (line %0d, h %0d) expected %h got %h",
                         $time, l, v, check_h, expected[l], pixel[l]);
            end
        end
    endtask

    initial begin
        bit ok;
        int n;
        value_errors = 0;
        other_errors = 0;
        lfsr_q    = 16'd19528;
        cyc       = 0;
        h         = '0;
        pixel_cen = 1'b0;
        hblank    = 1'b0;
        active    = 1'b1;
        vrender   = '0;
        reset96   = 1'b1;
        for (int l = 0; l < num_layers; l++) begin
            map_dout[l]  = '0;
            gfx_ok[l]    = 1'b0;
            gfx_data[l]  = '0;
            gfx_wait[l]  = 0;
            scroll_x[l]  = '0;
            scroll_y[l]  = '0;
            scroll_xo[l] = '0;
            scroll_yo[l] = '0;
        end
        $readmemh("scroll_input.txt", vec_mem);
        ok = !$isunknown(vec_mem[num_vec * vec_words - 1]);
        if (!ok) begin
            other_errors++;
            $display("stimulus file scroll_input.txt could not be read completely");
        end
        repeat (4) @(negedge clk96);
        reset96 = 1'b0;

        if (ok) begin
            apply_vector(0);
            // nothing rendered or shown before the first blank
            n = 0;
            while (!hblank && n < wait_limit) begin
                check_idle();
                tick();
                n++;
            end
            if (!hblank) begin
                ok = 1'b0;
                other_errors++;
                $display("timeout at %0t waiting for the first hblank", $time);
            end
        end
        for (int v = 0; v < num_vec && ok; v++) begin
            if (v > 0) apply_vector(v);
            wait_blank(1'b1, ok);
            if (ok) wait_blank(1'b0, ok);
            if (ok) wait_column(check_h, ok);
            if (ok) begin
                tick();    // pixel registered on that edge
                check_pixels(v);
            end else begin
                other_errors++;
            end
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- video_timing_pkg.sv
package video_timing_pkg;

    // layer count and visible line
    localparam int num_layers = 3;
    localparam int screen_w   = 320;    // visible pixels per line

    // h/v counter width, also the line-buffer address width
    localparam int hpos_w    = 9;
    localparam int buf_depth = 1 << hpos_w;

    // 21 columns cover 320 pixels plus the fine-scroll overhang
    localparam int tiles_per_line = 21;
    localparam int tile_px        = 16;    // square tiles
    localparam int slice_px       = 8;     // pixels per graphics word

endpackage
